//--- stream_read_unit.f
source/read_stream_pkg.sv
source/read_engine.sv
source/read_command_buffer.sv
source/read_data_collector.sv
source/stream_read_unit.sv
dv/tb_clock_gen.sv
dv/tb_stream_read_unit.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module tb_stream_read_unit \
	-f stream_read_unit.f

output=$(./obj_dir/Vtb_stream_read_unit 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -Fqx "Done: no errors"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

//--- dv/tb_stream_read_unit.sv
module tb_stream_read_unit;

	timeunit 1ns;
	timeprecision 100ps;

	import read_stream_pkg::*;

	logic           clock;
	logic           rstn;
	logic           enabled;
	logic           wed_valid;
	address_t       wed_array_address;
	element_count_t wed_element_count;
	logic           command_grant;
	logic           response_valid;
	element_count_t response_element_count;
	logic           data_valid;
	element_t       data_element;
	logic           command_valid;
	command_code_t  command_code;
	address_t       command_address;
	byte_size_t     command_byte_size;
	element_count_t command_element_count;
	cu_id_t         command_cu_id;
	logic           job_done;
	element_count_t job_element_count_done;
	element_t       job_checksum;
	element_count_t data_element_count;

	// commands the running job should produce in order
	command_code_t  expected_code[$];
	address_t       expected_address[$];
	byte_size_t     expected_size[$];
	element_count_t expected_count[$];

	// taken by the responder and not answered yet
	address_t       pending_address[$];
	element_count_t pending_count[$];

	element_count_t job_length[$];
	address_t       job_address[$];

	element_count_t current_length;
	element_count_t issued_element_total;
	element_t       expected_checksum;
	int             commands_in_job;
	int             responses_in_job;
	logic           job_active;
	logic           job_finished;
	logic           hold_commands;
	logic [31:0]    job_lfsr;
	logic [31:0]    grant_lfsr;
	logic [31:0]    delay_lfsr;

	tb_clock_gen u_clock_gen (.*);

	stream_read_unit u_stream_read_unit (.*);

	//////////////////////////////////////////////////////////////////////
	// random numbers and reference rules
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h80200003;
		return state >> 1;
	endfunction

	// one lfsr step per bit
	task automatic take_bits(inout logic [31:0] state, input int count,
			output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits  = {bits[30:0], state[0]};
			state = lfsr_step(state);
		end
	endtask

	// smallest power of two not below the tail's byte count
	function automatic byte_size_t tail_bytes(input element_count_t count);
		return byte_size_t'(1 << $clog2(4 * int'(count)));
	endfunction

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("Done: errors found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_code(input string name, input command_code_t got,
			input command_code_t want);
		if (got !== want) begin
			$display("FAILED at %0t: %s got %h, expected %h", $time, name, got, want);
			stop_run();
		end
	endtask

	task automatic check_address(input string name, input address_t got, input address_t want);
		if (got !== want) begin
			$display("FAILED at %0t: %s got %h, expected %h", $time, name, got, want);
			stop_run();
		end
	endtask

	task automatic check_byte_size(input string name, input byte_size_t got,
			input byte_size_t want);
		if (got !== want) begin
			$display("FAILED at %0t: %s got %h, expected %h", $time, name, got, want);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input element_count_t got,
			input element_count_t want);
		if (got !== want) begin
			$display("FAILED at %0t: %s got %h, expected %h", $time, name, got, want);
			stop_run();
		end
	endtask

	task automatic check_element(input string name, input element_t got, input element_t want);
		if (got !== want) begin
			$display("FAILED at %0t: %s got %h, expected %h", $time, name, got, want);
			stop_run();
		end
	endtask

	task automatic check_cu_id(input string name, input cu_id_t got, input cu_id_t want);
		if (got !== want) begin
			$display("FAILED at %0t: %s got %h, expected %h", $time, name, got, want);
			stop_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// job generator
	//////////////////////////////////////////////////////////////////////

	task automatic start_job(input element_count_t length, input address_t address);
		element_count_t left;
		int             index;
		left              = length;
		index             = 0;
		expected_checksum = '0;
		for (int k = 0; k < int'(length); k++)
			expected_checksum += element_t'(address + address_t'(4 * k));
		// 32 elements per 128 byte line and the rest as one partial read
		while (left != 0) begin
			expected_address.push_back(address + address_t'(128 * index));
			if (left > 32) begin
				expected_code.push_back(READ_CL_NA);
				expected_size.push_back(byte_size_t'(128));
				expected_count.push_back(element_count_t'(32));
				left = left - 32;
			end else begin
				expected_code.push_back(READ_PNA);
				expected_size.push_back(tail_bytes(left));
				expected_count.push_back(left);
				left = 0;
			end
			index++;
		end
		commands_in_job      = index;
		responses_in_job     = 0;
		issued_element_total = '0;
		current_length       = length;
		job_active           = 1'b1;
		job_finished         = 1'b0;
		wed_valid         <= 1'b1;
		wed_array_address <= address;
		wed_element_count <= length;
		@(posedge clock);
		wed_valid <= 1'b0;
	endtask

	task automatic wait_job_done();
		while (!job_finished)
			@(posedge clock);
	endtask

	task automatic watchdog(input int cycles);
		repeat (cycles) @(posedge clock);
		$display("ERROR at %0t: run did not finish within %0d cycles", $time, cycles);
		stop_run();
	endtask

	//////////////////////////////////////////////////////////////////////
	// memory side model
	//////////////////////////////////////////////////////////////////////

	task automatic check_issued_command();
		if (!job_active || hold_commands) begin
			$display("ERROR at %0t: command_valid with no enabled job running", $time);
			stop_run();
		end else if (expected_code.size() == 0) begin
			$display("ERROR at %0t: more commands than the job splits into", $time);
			stop_run();
		end else begin
			check_code("command_code", command_code, expected_code.pop_front());
			check_address("command_address", command_address, expected_address.pop_front());
			check_byte_size("command_byte_size", command_byte_size, expected_size.pop_front());
			check_count("command_element_count", command_element_count,
				expected_count.pop_front());
			check_cu_id("command_cu_id", command_cu_id, cu_read_id);
			issued_element_total += command_element_count;
			pending_address.push_back(command_address);
			pending_count.push_back(command_element_count);
		end
	endtask

	task automatic check_completion();
		if (!job_active) begin
			$display("ERROR at %0t: job_done pulsed with no job running", $time);
			stop_run();
		end else if (expected_code.size() != 0 || responses_in_job != commands_in_job) begin
			$display("ERROR at %0t: job_done came before every command was answered", $time);
			stop_run();
		end else begin
			check_count("sum of command_element_count", issued_element_total, current_length);
			check_count("job_element_count_done", job_element_count_done, current_length);
			check_count("data_element_count", data_element_count, current_length);
			check_element("job_checksum", job_checksum, expected_checksum);
			job_active   = 1'b0;
			job_finished = 1'b1;
		end
	endtask

	// data strobes first and then one response per command
	task automatic serve_command();
		address_t       address;
		element_count_t count;
		logic [31:0]    delay;
		address = pending_address.pop_front();
		count   = pending_count.pop_front();
		take_bits(delay_lfsr, 3, delay);
		repeat (delay) @(posedge clock);
		for (int i = 0; i < int'(count); i++) begin
			data_valid   <= 1'b1;
			data_element <= element_t'(address + address_t'(4 * i));
			@(posedge clock);
		end
		data_valid             <= 1'b0;
		response_valid         <= 1'b1;
		response_element_count <= count;
		responses_in_job++;
		@(posedge clock);
		response_valid <= 1'b0;
	endtask

	task automatic drive_grant_pattern();
		logic [31:0] level;
		logic [31:0] stretch;
		forever begin
			take_bits(grant_lfsr, 1, level);
			take_bits(grant_lfsr, 6, stretch);
			command_grant <= level[0];
			repeat (stretch + 1) @(posedge clock);
		end
	endtask

	always @(negedge clock) begin
		if (rstn && command_valid)
			check_issued_command();
		if (rstn && job_done)
			check_completion();
	end

	initial begin
		delay_lfsr             = 32'heac4;
		data_valid             = 1'b0;
		data_element           = '0;
		response_valid         = 1'b0;
		response_element_count = '0;
		forever begin
			@(posedge clock);
			if (pending_count.size() != 0)
				serve_command();
		end
	end

	initial begin
		grant_lfsr    = 32'heac4;
		command_grant = 1'b0;
		@(posedge rstn);
		@(posedge clock);
		drive_grant_pattern();
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int          total_elements;
		logic [31:0] bits;
		logic [31:0] high;
		job_lfsr          = 32'heac4;
		enabled           = 1'b0;
		wed_valid         = 1'b0;
		wed_array_address = '0;
		wed_element_count = '0;
		job_active        = 1'b0;
		job_finished      = 1'b0;
		hold_commands     = 1'b0;
		total_elements    = 0;
		for (int j = 0; j < 16; j++) begin
			take_bits(job_lfsr, 9, bits);
			job_length.push_back(element_count_t'(bits % 300 + 1));
			take_bits(job_lfsr, 16, high);
			take_bits(job_lfsr, 25, bits);
			job_address.push_back({16'h0, high[15:0], 32'h0} | (address_t'(bits) << 7));
		end
		// edge lengths go first
		job_length[0] = 1;
		job_length[1] = 32;
		job_length[2] = 33;
		job_length[3] = 300;
		foreach (job_length[j])
			total_elements += int'(job_length[j]);
		fork
			watchdog(40 * total_elements + 2000);
		join_none

		@(posedge rstn);
		@(posedge clock);
		enabled <= 1'b1;
		// quiet window where nothing may come out
		repeat (20) @(posedge clock);

		for (int j = 0; j < 8; j++) begin
			start_job(job_length[j], job_address[j]);
			wait_job_done();
		end

		// job sent while disabled must wait for enabled
		enabled       <= 1'b0;
		hold_commands = 1'b1;
		repeat (4) @(posedge clock);
		start_job(job_length[8], job_address[8]);
		repeat (30) @(posedge clock);
		enabled       <= 1'b1;
		hold_commands = 1'b0;
		wait_job_done();

		for (int j = 9; j < 16; j++) begin
			start_job(job_length[j], job_address[j]);
			wait_job_done();
		end

		// stray commands or job_done pulses still show up here
		repeat (10) @(posedge clock);
		$display("Done: no errors");
		$finish;
	end

endmodule

//--- dv/tb_clock_gen.sv
module tb_clock_gen (
	output logic clock,
	output logic rstn
);

	timeunit 1ns;
	timeprecision 100ps;

	// 4 ns period
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		rstn = 1'b0;
		repeat (4) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

//--- source/stream_read_unit.sv
module stream_read_unit (
	input  logic                            clock,
	input  logic                            rstn,
	input  logic                            enabled,
	input  logic                            wed_valid,
	input  read_stream_pkg::address_t       wed_array_address,
	input  read_stream_pkg::element_count_t wed_element_count,
	input  logic                            command_grant,
	input  logic                            response_valid,
	input  read_stream_pkg::element_count_t response_element_count,
	input  logic                            data_valid,
	input  read_stream_pkg::element_t       data_element,
	output logic                            command_valid,
	output read_stream_pkg::command_code_t  command_code,
	output read_stream_pkg::address_t       command_address,
	output read_stream_pkg::byte_size_t     command_byte_size,
	output read_stream_pkg::element_count_t command_element_count,
	output read_stream_pkg::cu_id_t         command_cu_id,
	output logic                            job_done,
	output read_stream_pkg::element_count_t job_element_count_done,
	output read_stream_pkg::element_t       job_checksum,
	output read_stream_pkg::element_count_t data_element_count
);

	import read_stream_pkg::*;

	// engine to buffer
	logic           push;
	command_code_t  engine_command_code;
	address_t       engine_command_address;
	byte_size_t     engine_command_byte_size;
	element_count_t engine_command_element_count;
	cu_id_t         engine_command_cu_id;
	logic           command_buffer_alfull;
	logic           job_start;

	read_engine u_read_engine (
		.clock                 (clock),
		.rstn                  (rstn),
		.enabled               (enabled),
		.wed_valid             (wed_valid),
		.wed_array_address     (wed_array_address),
		.wed_element_count     (wed_element_count),
		.response_valid        (response_valid),
		.response_element_count(response_element_count),
		.command_buffer_alfull (command_buffer_alfull),
		.push                  (push),
		.command_code          (engine_command_code),
		.command_address       (engine_command_address),
		.command_byte_size     (engine_command_byte_size),
		.command_element_count (engine_command_element_count),
		.command_cu_id         (engine_command_cu_id),
		.job_start             (job_start),
		.job_done              (job_done),
		.job_element_count_done(job_element_count_done)
	);

	read_command_buffer u_read_command_buffer (
		.clock                   (clock),
		.rstn                    (rstn),
		.push                    (push),
		.command_code_in         (engine_command_code),
		.command_address_in      (engine_command_address),
		.command_byte_size_in    (engine_command_byte_size),
		.command_element_count_in(engine_command_element_count),
		.command_cu_id_in        (engine_command_cu_id),
		.command_grant           (command_grant),
		.command_buffer_alfull   (command_buffer_alfull),
		.command_valid           (command_valid),
		.command_code            (command_code),
		.command_address         (command_address),
		.command_byte_size       (command_byte_size),
		.command_element_count   (command_element_count),
		.command_cu_id           (command_cu_id)
	);

	read_data_collector u_read_data_collector (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.job_start         (job_start),
		.data_valid        (data_valid),
		.data_element      (data_element),
		.job_checksum      (job_checksum),
		.data_element_count(data_element_count)
	);

endmodule

//--- source/read_data_collector.sv
module read_data_collector (
	input  logic                            clock,
	input  logic                            rstn,
	input  logic                            enabled,
	input  logic                            job_start,
	input  logic                            data_valid,
	input  read_stream_pkg::element_t       data_element,
	output read_stream_pkg::element_t       job_checksum,
	output read_stream_pkg::element_count_t data_element_count
);

	import read_stream_pkg::*;

	logic     enabled_in;
	logic     data_valid_latched;
	element_t data_element_latched;

	//////////////////////////////////////////////////////////////////////
	// input registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled_in <= 1'b0;
		end else begin
			enabled_in <= enabled;
		end
	end

	// strobe holds its value while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			data_valid_latched <= 1'b0;
		end else if (enabled_in) begin
			data_valid_latched <= data_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (enabled_in)
			data_element_latched <= data_element;
	end

	//////////////////////////////////////////////////////////////////////
	// checksum and element count
	//////////////////////////////////////////////////////////////////////

	// 32-bit sum, wraps on overflow
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_checksum <= '0;
		end else if (job_start) begin
			job_checksum <= '0;
		end else if (enabled_in && data_valid_latched) begin
			job_checksum <= job_checksum + data_element_latched;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			data_element_count <= '0;
		end else if (job_start) begin
			data_element_count <= '0;
		end else if (enabled_in && data_valid_latched) begin
			data_element_count <= data_element_count + 1'b1;
		end
	end

endmodule

//--- source/read_command_buffer.sv
module read_command_buffer (
	input  logic                            clock,
	input  logic                            rstn,
	input  logic                            push,
	input  read_stream_pkg::command_code_t  command_code_in,
	input  read_stream_pkg::address_t       command_address_in,
	input  read_stream_pkg::byte_size_t     command_byte_size_in,
	input  read_stream_pkg::element_count_t command_element_count_in,
	input  read_stream_pkg::cu_id_t         command_cu_id_in,
	input  logic                            command_grant,
	output logic                            command_buffer_alfull,
	output logic                            command_valid,
	output read_stream_pkg::command_code_t  command_code,
	output read_stream_pkg::address_t       command_address,
	output read_stream_pkg::byte_size_t     command_byte_size,
	output read_stream_pkg::element_count_t command_element_count,
	output read_stream_pkg::cu_id_t         command_cu_id
);

	import read_stream_pkg::*;

	command_code_t  code_mem    [command_buffer_depth];
	address_t       address_mem [command_buffer_depth];
	byte_size_t     size_mem    [command_buffer_depth];
	element_count_t count_mem   [command_buffer_depth];
	cu_id_t         cu_id_mem   [command_buffer_depth];

	logic [command_buffer_pointer_width-1:0] write_pointer;
	logic [command_buffer_pointer_width-1:0] read_pointer;
	logic [command_buffer_count_width-1:0]   occupancy;

	logic write_enable;
	logic issue;

	// a push into a full queue is dropped
	assign write_enable = push && (occupancy != command_buffer_count_width'(command_buffer_depth));
	assign issue        = command_grant && (occupancy != '0);

	assign command_buffer_alfull =
		occupancy >= command_buffer_count_width'(read_stream_pkg::command_buffer_alfull);

	//////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_pointer <= '0;
			read_pointer  <= '0;
			occupancy     <= '0;
		end else begin
			if (write_enable)
				write_pointer <= write_pointer + 1'b1;
			if (issue)
				read_pointer <= read_pointer + 1'b1;
			occupancy <= occupancy + command_buffer_count_width'(write_enable) -
				command_buffer_count_width'(issue);
		end
	end

	always_ff @(posedge clock) begin
		if (write_enable) begin
			code_mem[write_pointer]    <= command_code_in;
			address_mem[write_pointer] <= command_address_in;
			size_mem[write_pointer]    <= command_byte_size_in;
			count_mem[write_pointer]   <= command_element_count_in;
			cu_id_mem[write_pointer]   <= command_cu_id_in;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// issue side
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command_valid <= 1'b0;
		end else begin
			command_valid <= issue;
		end
	end

	// head entry held on the outputs while command_valid is high
	always_ff @(posedge clock) begin
		if (issue) begin
			command_code          <= code_mem[read_pointer];
			command_address       <= address_mem[read_pointer];
			command_byte_size     <= size_mem[read_pointer];
			command_element_count <= count_mem[read_pointer];
			command_cu_id         <= cu_id_mem[read_pointer];
		end
	end

endmodule

//--- source/read_engine.sv
module read_engine (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled,
	input  logic                           wed_valid,
	input  read_stream_pkg::address_t      wed_array_address,
	input  read_stream_pkg::element_count_t wed_element_count,
	input  logic                           response_valid,
	input  read_stream_pkg::element_count_t response_element_count,
	input  logic                           command_buffer_alfull,
	output logic                           push,
	output read_stream_pkg::command_code_t command_code,
	output read_stream_pkg::address_t      command_address,
	output read_stream_pkg::byte_size_t    command_byte_size,
	output read_stream_pkg::element_count_t command_element_count,
	output read_stream_pkg::cu_id_t        command_cu_id,
	output logic                           job_start,
	output logic                           job_done,
	output read_stream_pkg::element_count_t job_element_count_done
);

	import read_stream_pkg::*;

	logic           enabled_in;
	logic           wed_valid_latched;
	address_t       wed_array_address_latched;
	element_count_t wed_element_count_latched;
	logic           response_valid_latched;
	element_count_t response_element_count_latched;
	logic           command_buffer_alfull_latched;

	// job copy the driver works from
	address_t       job_address;
	element_count_t job_element_count;
	element_count_t remaining_count;
	address_t       next_offset;

	read_state_t current_state;
	read_state_t next_state;
	logic        job_accept;
	logic        send_command;

	//////////////////////////////////////////////////////////////////////
	// input registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled_in <= 1'b0;
		end else begin
			enabled_in <= enabled;
		end
	end

	// job strobe waits here until an enabled cycle has seen it
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_valid_latched <= 1'b0;
		end else if (wed_valid) begin
			wed_valid_latched <= 1'b1;
		end else if (enabled_in) begin
			wed_valid_latched <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (wed_valid) begin
			wed_array_address_latched <= wed_array_address;
			wed_element_count_latched <= wed_element_count;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_valid_latched        <= 1'b0;
			command_buffer_alfull_latched <= 1'b0;
		end else begin
			command_buffer_alfull_latched <= command_buffer_alfull;
			if (enabled_in)
				response_valid_latched <= response_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (enabled_in)
			response_element_count_latched <= response_element_count;
	end

	//////////////////////////////////////////////////////////////////////
	// read state machine
	//////////////////////////////////////////////////////////////////////

	assign job_accept   = enabled_in && (current_state == READ_STREAM_IDLE) && wed_valid_latched;
	assign send_command = (current_state == READ_STREAM_REQ) && !command_buffer_alfull_latched &&
		(remaining_count != '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			current_state <= READ_STREAM_RESET;
		end else if (enabled_in) begin
			current_state <= next_state;
		end
	end

	always_comb begin
		next_state = current_state;
		case (current_state)
			READ_STREAM_RESET: next_state = READ_STREAM_IDLE;
			READ_STREAM_IDLE: begin
				if (wed_valid_latched)
					next_state = READ_STREAM_SET;
			end
			READ_STREAM_SET:   next_state = READ_STREAM_START;
			READ_STREAM_START: next_state = READ_STREAM_REQ;
			READ_STREAM_REQ: begin
				if (remaining_count == '0)
					next_state = READ_STREAM_FINAL;
			end
			READ_STREAM_FINAL: begin
				if (job_element_count_done == job_element_count)
					next_state = READ_STREAM_IDLE;
			end
			default: next_state = READ_STREAM_RESET;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_start <= 1'b0;
		end else begin
			job_start <= job_accept;
		end
	end

	assign job_done = enabled_in && (current_state == READ_STREAM_FINAL) &&
		(job_element_count_done == job_element_count);

	//////////////////////////////////////////////////////////////////////
	// command driver
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (enabled_in && (current_state == READ_STREAM_SET)) begin
			job_address       <= wed_array_address_latched;
			job_element_count <= wed_element_count_latched;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			push            <= 1'b0;
			remaining_count <= '0;
			next_offset     <= '0;
		end else begin
			push <= 1'b0;
			if (enabled_in && (current_state == READ_STREAM_SET)) begin
				remaining_count <= wed_element_count_latched;
				next_offset     <= '0;
			end else if (enabled_in && send_command) begin
				push        <= 1'b1;
				next_offset <= next_offset + address_t'(cacheline_bytes);
				if (remaining_count > element_count_t'(cacheline_elements))
					remaining_count <= remaining_count - element_count_t'(cacheline_elements);
				else
					remaining_count <= '0;
			end
		end
	end

	// full lines first, the tail goes out as one partial read
	always_ff @(posedge clock) begin
		if (enabled_in && send_command) begin
			command_address <= job_address + next_offset;
			command_cu_id   <= cu_read_id;
			if (remaining_count > element_count_t'(cacheline_elements)) begin
				command_code          <= READ_CL_NA;
				command_byte_size     <= byte_size_t'(cacheline_bytes);
				command_element_count <= element_count_t'(cacheline_elements);
			end else begin
				command_code          <= READ_PNA;
				command_byte_size     <= read_stream_pkg::command_byte_size(remaining_count);
				command_element_count <= remaining_count;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// response tracking
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_element_count_done <= '0;
		end else if (enabled_in) begin
			if (current_state == READ_STREAM_SET)
				job_element_count_done <= '0;
			else if (response_valid_latched)
				job_element_count_done <= job_element_count_done + response_element_count_latched;
		end
	end

endmodule

//--- source/read_stream_pkg.sv
package read_stream_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths with a meaning
	//////////////////////////////////////////////////////////////////////

	// byte address into host memory
	typedef logic [63:0] address_t;
	// number of 32-bit elements
	typedef logic [31:0] element_count_t;
	typedef logic [31:0] element_t;
	// byte size field of a read command
	typedef logic [11:0] byte_size_t;
	typedef logic [7:0]  cu_id_t;

	//////////////////////////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////////////////////////

	// capi read opcodes
	typedef enum logic [12:0] {
		READ_CL_NA = 13'h0A00,
		READ_PNA   = 13'h0E00
	} command_code_t;

	typedef enum logic [2:0] {
		READ_STREAM_RESET,
		READ_STREAM_IDLE,
		READ_STREAM_SET,
		READ_STREAM_START,
		READ_STREAM_REQ,
		READ_STREAM_FINAL
	} read_state_t;

	//////////////////////////////////////////////////////////////////////
	// constants
	//////////////////////////////////////////////////////////////////////

	localparam int cacheline_bytes    = 128;
	localparam int cacheline_elements = 32;

	localparam int command_buffer_depth         = 8;
	// two commands may still be on their way from the engine
	localparam int command_buffer_alfull        = 6;
	localparam int command_buffer_pointer_width = $clog2(command_buffer_depth);
	localparam int command_buffer_count_width   = command_buffer_pointer_width + 1;

	localparam cu_id_t cu_read_id = 8'h10;

	// smallest power of two bytes holding count elements, count in 1..32
	function automatic byte_size_t command_byte_size(input element_count_t count);
		byte_size_t     size;
		element_count_t bytes;
		size  = 12'd4;
		bytes = count << 2;
		for (int i = 0; i < 5; i++) begin
			if (element_count_t'(size) < bytes)
				size = size << 1;
		end
		return size;
	endfunction

endpackage
